// ==== Makefile ====
TOP = tb_telemetry_uart

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== char_fifo.sv ====
`timescale 1ns/100ps

module char_fifo (
    input  logic               CLK,
    input  logic               RST,
    input  msg_pkg::msg_char_t i_char,
    output msg_pkg::msg_char_t o_head,
    input  logic               i_pop,
    output logic               o_credit
);
    import msg_pkg::*;

    logic [7:0]        mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CRED_W-1:0] count;
    logic              wr;
    logic              rd;

    assign wr = i_char.valid;                   // Credits keep this below depth
    assign rd = i_pop && (count != '0);

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (wr) begin
            mem[wr_ptr] <= i_char.code;
        end
    end

    assign o_head   = '{valid: (count != '0), code: mem[rd_ptr]};
    assign o_credit = rd;                       // One credit back per pop

endmodule

// ==== message_formatter.sv ====
`timescale 1ns/100ps

module message_formatter (
    input  logic               CLK,
    input  logic               RST,
    input  msg_pkg::msg_rec_u  i_rec,
    input  logic               i_rec_full,
    output logic               o_take,
    output msg_pkg::msg_char_t o_char,
    input  logic               i_credit
);
    import msg_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEX,
        ST_SEP,
        ST_CR,
        ST_LF
    } state_t;

    state_t                state;
    msg_rec_u              sr;
    logic [DIG_W-1:0]      digit_cnt;
    logic [WORD_IDX_W-1:0] word_cnt;
    logic [CRED_W-1:0]     credit_cnt;
    logic                  has_credit;
    logic                  emit;
    logic                  char_valid;
    logic [7:0]            char_code;
    logic [7:0]            next_code;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return CH_DIG0 + 8'(nib);
        end
        return CH_HEXA + 8'(nib) - 8'd10;
    endfunction

    assign has_credit = (credit_cnt != '0);
    assign emit       = has_credit && (state != ST_IDLE);
    assign o_take     = (state == ST_IDLE) && i_rec_full && has_credit;

    always_comb begin
        case (state)
            ST_SEP:  next_code = CH_SEP;
            ST_CR:   next_code = CH_CR;
            ST_LF:   next_code = CH_LF;
            default: next_code = hex_char(sr.nibbles[0]);
        endcase
    end

    // ----------------------------------------------------------
    // Line sequencing
    // ----------------------------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state     <= ST_IDLE;
            digit_cnt <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: if (o_take) begin
                    state     <= ST_HEX;
                    digit_cnt <= DIG_W'(DIG_PER_WORD - 1);
                    word_cnt  <= WORD_IDX_W'(WORD_COUNT - 1);
                end
                ST_HEX: if (has_credit) begin
                    if (digit_cnt == '0) begin
                        state <= (word_cnt == '0) ? ST_CR : ST_SEP;  // Last word ends the line
                    end else begin
                        digit_cnt <= digit_cnt - 1'b1;
                    end
                end
                ST_SEP: if (has_credit) begin
                    state     <= ST_HEX;
                    digit_cnt <= DIG_W'(DIG_PER_WORD - 1);
                    word_cnt  <= word_cnt - 1'b1;
                end
                ST_CR:   if (has_credit) state <= ST_LF;
                ST_LF:   if (has_credit) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Nibble shifter, top nibble is the next digit
    always_ff @(posedge CLK) begin
        if (o_take) begin
            sr <= i_rec;
        end else if ((state == ST_HEX) && has_credit) begin
            sr.nibbles <= {sr.nibbles[1:NIB_COUNT-1], 4'h0};
        end
    end

    // ----------------------------------------------------------
    // Credits and character output
    // ----------------------------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            credit_cnt <= CRED_W'(FIFO_DEPTH);
            char_valid <= 1'b0;
        end else begin
            char_valid <= emit;
            case ({emit, i_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;      // Spend and return cancel
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (emit) begin
            char_code <= next_code;
        end
    end

    assign o_char = '{valid: char_valid, code: char_code};

endmodule

// ==== msg_pkg.sv ====
package msg_pkg;

    // ----------------------------------------------------------
    // Record and line geometry
    // ----------------------------------------------------------
    localparam int WORD_W       = 24;
    localparam int WORD_COUNT   = 2;
    localparam int REC_W        = WORD_W * WORD_COUNT;
    localparam int NIB_COUNT    = REC_W / 4;
    localparam int DIG_PER_WORD = WORD_W / 4;
    localparam int LINE_LEN     = NIB_COUNT + (WORD_COUNT - 1) + 2; // Digits, separators, CR LF
    localparam int DIG_W        = $clog2(DIG_PER_WORD);
    localparam int WORD_IDX_W   = $clog2(WORD_COUNT);

    // ----------------------------------------------------------
    // Character FIFO and UART
    // ----------------------------------------------------------
    localparam int FIFO_DEPTH = 8;                      // Also the initial credit count
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CRED_W     = $clog2(FIFO_DEPTH + 1);
    localparam int BAUD_DIV   = 4;                      // Clocks per bit
    localparam int BAUD_W     = $clog2(BAUD_DIV);

    localparam logic [7:0] CH_SEP  = "_";
    localparam logic [7:0] CH_CR   = 8'h0D;
    localparam logic [7:0] CH_LF   = 8'h0A;
    localparam logic [7:0] CH_DIG0 = "0";
    localparam logic [7:0] CH_HEXA = "A";

    // Word 0 and nibble 0 are the most significant, printed first
    typedef union packed {
        logic [0:WORD_COUNT-1][WORD_W-1:0] words;
        logic [0:NIB_COUNT-1][3:0]         nibbles;
    } msg_rec_u;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } msg_char_t;

endpackage

// ==== sample_capture.sv ====
`timescale 1ns/100ps

module sample_capture (
    input  logic              CLK,
    input  logic              RST,
    input  logic              i_sample_stb,
    input  msg_pkg::msg_rec_u i_sample,
    input  logic              i_take,
    output msg_pkg::msg_rec_u o_rec,
    output logic              o_rec_full,
    output logic [7:0]        o_drop_count
);
    import msg_pkg::*;

    logic     rec_full;
    logic [7:0] drop_count;
    msg_rec_u rec;
    logic     load;

    assign load = i_sample_stb && !rec_full;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rec_full <= 1'b0;
        end else if (load) begin
            rec_full <= 1'b1;
        end else if (i_take) begin
            rec_full <= 1'b0;                   // Formatter has the record
        end
    end

    // Strobe meets a held record
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            drop_count <= 8'd0;
        end else if (i_sample_stb && rec_full && (drop_count != 8'hFF)) begin
            drop_count <= drop_count + 8'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            for (int w = 0; w < WORD_COUNT; w++) begin
                rec.words[w] <= i_sample.words[w];
            end
        end
    end

    assign o_rec        = rec;
    assign o_rec_full   = rec_full;
    assign o_drop_count = drop_count;

endmodule

// ==== sim.f ====
msg_pkg.sv
sample_capture.sv
message_formatter.sv
char_fifo.sv
uart_tx.sv
telemetry_uart_top.sv
telemetry_uart_assert.sv
tb_telemetry_uart.sv

// ==== tb_telemetry_uart.sv ====
`timescale 1ns/100ps

module tb_telemetry_uart;
    import msg_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int FRAME_CYCLES  = 10 * BAUD_DIV;
    localparam int LINES_PLANNED = 12;
    localparam int TIMEOUT_NS    = LINES_PLANNED * LINE_LEN * FRAME_CYCLES * CLK_PERIOD + 11200;
    localparam logic [127:0] HEX_DIGITS = "0123456789ABCDEF";

    logic       CLK;
    logic       RST;
    logic       i_sample_stb;
    msg_rec_u   i_sample;
    logic       o_txd;
    logic [7:0] o_drop_count;

    logic [8*LINE_LEN-1:0] exp_q[$];
    logic [8*LINE_LEN-1:0] rx_line;
    int                    rx_chars;
    int                    lines_seen;
    int                    errors;
    logic [31:0]           rand_state;
    logic [7:0]            drops_before;
    logic [REC_W-1:0]      burst_rec;

    telemetry_uart_top UUT (
        .CLK          (CLK),
        .RST          (RST),
        .i_sample_stb (i_sample_stb),
        .i_sample     (i_sample),
        .o_txd        (o_txd),
        .o_drop_count (o_drop_count)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic [REC_W-1:0] random_record();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:8], lo[31:8]};
    endfunction

    // Text of one line, shifted in from the right
    function automatic logic [8*LINE_LEN-1:0] expect_line(input logic [REC_W-1:0] rec);
        logic [8*LINE_LEN-1:0] s;
        logic [3:0]            nib;
        s = '0;
        for (int i = 0; i < NIB_COUNT; i++) begin
            if (i != 0 && (i % DIG_PER_WORD) == 0) begin
                s = {s[8*LINE_LEN-9:0], CH_SEP};
            end
            nib = rec[REC_W-1-4*i -: 4];
            s = {s[8*LINE_LEN-9:0], HEX_DIGITS[8*(15-int'(nib)) +: 8]};
        end
        return {s[8*LINE_LEN-17:0], CH_CR, CH_LF};
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic send_record(input logic [REC_W-1:0] rec);
        @(negedge CLK);
        i_sample_stb = 1'b1;
        i_sample     = rec;
        exp_q.push_back(expect_line(rec));
        @(negedge CLK);
        i_sample_stb = 1'b0;
    endtask

    task automatic wait_lines();
        while (exp_q.size() != 0 || rx_chars != 0) begin
            @(negedge CLK);
        end
    endtask

    task automatic check_line();
        logic [8*LINE_LEN-1:0] want;
        lines_seen++;
        rx_chars = 0;
        want = '0;                              // No record left to match
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
        end
        assert (rx_line == want) else
            flag_error($sformatf("line %0d expected \"%s\" got \"%s\"", lines_seen,
                                 want[8*LINE_LEN-1:16], rx_line[8*LINE_LEN-1:16]));
    endtask

    // ----------------------------------------------------------
    // UART receive model
    // ----------------------------------------------------------
    initial begin : uart_rx
        logic [7:0] ch;
        rx_chars   = 0;
        lines_seen = 0;
        rx_line    = '0;
        forever begin
            @(negedge CLK);
            if (!RST && !o_txd) begin
                @(negedge CLK);                 // Middle of start bit
                assert (!o_txd) else flag_error("start bit not held low");
                for (int b = 0; b < 8; b++) begin
                    repeat (BAUD_DIV) @(negedge CLK);
                    ch[b] = o_txd;
                end
                repeat (BAUD_DIV) @(negedge CLK);
                assert (o_txd) else flag_error("stop bit low");
                rx_line = {rx_line[8*LINE_LEN-9:0], ch};
                rx_chars++;
                if (rx_chars == LINE_LEN) begin
                    check_line();
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin : stimulus
        RST          = 1'b1;
        i_sample_stb = 1'b0;
        i_sample     = '0;
        errors       = 0;
        rand_state   = 32'h9519;
        repeat (5) @(negedge CLK);
        RST = 1'b0;

        repeat (100) begin                      // Quiet line with no samples
            @(negedge CLK);
            assert (o_txd) else flag_error("txd left idle with no sample sent");
        end

        send_record('0);
        wait_lines();
        send_record('1);
        wait_lines();

        repeat (6) begin
            send_record(random_record());
            wait_lines();
        end

        // Second record arrives while the FIFO is full
        send_record(random_record());
        repeat (12) @(negedge CLK);
        send_record(random_record());
        wait_lines();

        // Formatter busy, then a three-strobe burst
        drops_before = o_drop_count;
        send_record(random_record());
        repeat (4) @(negedge CLK);
        for (int k = 0; k < 3; k++) begin
            burst_rec = random_record();
            if (k == 0) begin
                exp_q.push_back(expect_line(burst_rec));    // Only this one is held
            end
            i_sample_stb = 1'b1;
            i_sample     = burst_rec;
            @(negedge CLK);
        end
        i_sample_stb = 1'b0;
        @(negedge CLK);
        assert (o_drop_count == drops_before + 8'd2) else
            flag_error($sformatf("drop count %0d, expected %0d", o_drop_count,
                                 drops_before + 8'd2));
        wait_lines();
        repeat (2 * FRAME_CYCLES) @(negedge CLK);
        assert (rx_chars == 0 && o_txd) else
            flag_error("characters sent after the last expected line");

        $display("errors: %0d, assertion failures: %0d", errors, UUT.u_assert.fail_count);
        if (errors == 0 && UUT.u_assert.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== telemetry_uart_assert.sv ====
`timescale 1ns/100ps

module telemetry_uart_assert (
    input logic                       CLK,
    input logic                       RST,
    input logic [msg_pkg::CRED_W-1:0] i_credit_cnt,
    input logic [msg_pkg::CRED_W-1:0] i_fifo_count,
    input logic                       i_fifo_wr,
    input logic                       i_tx_busy,
    input logic                       i_txd,
    input logic                       i_take,
    input logic                       i_rec_full
);
    import msg_pkg::*;

    int fail_count = 0;

    credit_in_range: assert property (@(posedge CLK) disable iff (RST)
        i_credit_cnt <= CRED_W'(FIFO_DEPTH))
    else begin
        fail_count = fail_count + 1;
        $error("credit count above FIFO depth");
    end

    no_overflow: assert property (@(posedge CLK) disable iff (RST)
        i_fifo_wr |-> (i_fifo_count != CRED_W'(FIFO_DEPTH)))
    else begin
        fail_count = fail_count + 1;
        $error("write into a full character FIFO");
    end

    idle_high: assert property (@(posedge CLK) disable iff (RST)
        !i_tx_busy |-> i_txd)
    else begin
        fail_count = fail_count + 1;
        $error("txd low while the UART is idle");
    end

    // Holding register frees up on the edge after the take
    take_clears_full: assert property (@(posedge CLK) disable iff (RST)
        i_take |=> !i_rec_full)
    else begin
        fail_count = fail_count + 1;
        $error("record still held after take");
    end

endmodule

bind telemetry_uart_top telemetry_uart_assert u_assert (
    .CLK          (CLK),
    .RST          (RST),
    .i_credit_cnt (u_fmt.credit_cnt),
    .i_fifo_count (u_fifo.count),
    .i_fifo_wr    (u_fifo.wr),
    .i_tx_busy    (u_tx.busy),
    .i_txd        (o_txd),
    .i_take       (take),
    .i_rec_full   (rec_full)
);

// ==== telemetry_uart_top.sv ====
`timescale 1ns/100ps

module telemetry_uart_top (
    input  logic              CLK,
    input  logic              RST,
    input  logic              i_sample_stb,
    input  msg_pkg::msg_rec_u i_sample,
    output logic              o_txd,
    output logic [7:0]        o_drop_count
);
    import msg_pkg::*;

    msg_rec_u  rec;
    logic      rec_full;
    logic      take;
    msg_char_t fmt_char;
    msg_char_t fifo_head;
    logic      pop;
    logic      credit;

    sample_capture u_capture (
        .CLK          (CLK),
        .RST          (RST),
        .i_sample_stb (i_sample_stb),
        .i_sample     (i_sample),
        .i_take       (take),
        .o_rec        (rec),
        .o_rec_full   (rec_full),
        .o_drop_count (o_drop_count)
    );

    message_formatter u_fmt (
        .CLK        (CLK),
        .RST        (RST),
        .i_rec      (rec),
        .i_rec_full (rec_full),
        .o_take     (take),
        .o_char     (fmt_char),
        .i_credit   (credit)
    );

    char_fifo u_fifo (
        .CLK      (CLK),
        .RST      (RST),
        .i_char   (fmt_char),
        .o_head   (fifo_head),
        .i_pop    (pop),
        .o_credit (credit)
    );

    uart_tx u_tx (
        .CLK    (CLK),
        .RST    (RST),
        .i_head (fifo_head),
        .o_pop  (pop),
        .o_txd  (o_txd)
    );

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic               CLK,
    input  logic               RST,
    input  msg_pkg::msg_char_t i_head,
    output logic               o_pop,
    output logic               o_txd
);
    import msg_pkg::*;

    logic              busy;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic [8:0]        shreg;                   // Data bits then stop bit
    logic              txd;
    logic              bit_end;
    logic              frame_end;

    assign bit_end   = (baud_cnt == '0);
    assign frame_end = busy && bit_end && (bit_cnt == 4'd9);
    assign o_pop     = i_head.valid && (!busy || frame_end);  // Back to back frames

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else if (o_pop) begin
            busy     <= 1'b1;
            baud_cnt <= BAUD_W'(BAUD_DIV - 1);
            bit_cnt  <= '0;
            txd      <= 1'b0;                   // Start bit
        end else if (frame_end) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (bit_end) begin
                baud_cnt <= BAUD_W'(BAUD_DIV - 1);
                bit_cnt  <= bit_cnt + 4'd1;
                txd      <= shreg[0];
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // LSB first
    always_ff @(posedge CLK) begin
        if (o_pop) begin
            shreg <= {1'b1, i_head.code};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    assign o_txd = txd;

endmodule
